/* datapathTop.f */
source/datapathPkg.sv
source/issueStage.sv
source/registerFile.sv
source/aluUnit.sv
source/resultStage.sv
source/datapathTop.sv
dv/datapathAssertions.sv
dv/datapathTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the datapath testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module datapathTb \
	-f datapathTop.f \
	-Mdir obj_dir \
	-o datapathSim

# The simulator status is not trusted alone; the log decides.
./obj_dir/datapathSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* dv/datapathTb.sv */
`default_nettype none

module datapathTb;

	import datapathPkg::*;

	localparam int dataWidth = defaultDataWidth;
	localparam int regCount = defaultRegCount;
	localparam int idWidth = $clog2(regCount);
	localparam int randomCount = 200;
	localparam int chainCount = 40;
	localparam int gapCount = 12;
	localparam int limitRegs = 4;
	localparam int overflowCount = 60;
	localparam int instrTotal = regCount + randomCount + chainCount + gapCount
		+ 2 * limitRegs + overflowCount;
	localparam int runLimit = instrTotal * 8 * 4 + 5 * 8;
	localparam int maxSigned = (1 << (dataWidth - 1)) - 1;
	localparam int minSigned = -(1 << (dataWidth - 1));

	logic clk;
	logic reset;
	logic issue;
	aluOp op;
	logic [idWidth-1:0] srcA;
	logic [idWidth-1:0] srcB;
	logic [idWidth-1:0] dst;
	logic [dataWidth-1:0] imm;
	logic useImm;
	logic resultValid;
	logic [dataWidth-1:0] result;
	logic [idWidth-1:0] resultDst;
	logic zero;
	logic negative;
	logic overflow;

	integer seed;
	int errors = 0;
	int checks = 0;
	int cycleCount = 0;
	logic [dataWidth-1:0] modelRegs [regCount];
	logic [dataWidth-1:0] edgeValues [6];
	logic [dataWidth-1:0] expResult [$];
	logic [idWidth-1:0] expDst [$];
	logic expOverflow [$];
	int expCycle [$];
	string expName [$];
	logic haveResult = 1'b0;
	logic [dataWidth-1:0] heldResult;
	logic [idWidth-1:0] heldDst;
	logic heldOverflow;

	datapathTop #(.dataWidth(dataWidth), .regCount(regCount)) dut0 (
		.clk(clk), .reset(reset), .issue(issue), .op(op),
		.srcA(srcA), .srcB(srcB), .dst(dst), .imm(imm), .useImm(useImm),
		.resultValid(resultValid), .result(result), .resultDst(resultDst),
		.zero(zero), .negative(negative), .overflow(overflow)
	);

	always #4 clk = ~clk;

	always @(posedge clk) cycleCount <= cycleCount + 1;

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	function automatic logic [dataWidth-1:0] randomWord();
		logic [31:0] r;
		r = $random(seed);
		return r[dataWidth-1:0];
	endfunction

	function automatic logic [idWidth-1:0] randomId();
		logic [31:0] r;
		r = $random(seed);
		return r[idWidth-1:0];
	endfunction

	function automatic aluOp randomOp();
		logic [31:0] r;
		r = $random(seed);
		return aluOp'(r[2:0]);
	endfunction

	// shift amount is b modulo the word size.
	function automatic logic [dataWidth-1:0] modelResult(input aluOp opSel,
		input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		int amount;
		int signedA;
		logic [dataWidth-1:0] value;
		amount = int'(b) % dataWidth;
		signedA = int'($signed(a));
		case (opSel)
			opAdd: value = a + b;
			opSub: value = a - b;
			opAnd: value = a & b;
			opOr: value = a | b;
			opXor: value = a ^ b;
			opShiftLeft: value = a << amount;
			opShiftRightLogic: value = a >> amount;
			opShiftRightArith: value = dataWidth'(signedA >>> amount);
			default: value = '0;
		endcase
		return value;
	endfunction

	// exact signed sum out of range.
	function automatic logic modelOverflow(input aluOp opSel,
		input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		int exact;
		exact = 0;
		if (opSel == opAdd) begin
			exact = int'($signed(a)) + int'($signed(b));
		end else if (opSel == opSub) begin
			exact = int'($signed(a)) - int'($signed(b));
		end
		return (exact > maxSigned) || (exact < minSigned);
	endfunction

	task automatic issueInstr(input string name, input aluOp opSel,
		input logic [idWidth-1:0] idA, input logic [idWidth-1:0] idB,
		input logic [idWidth-1:0] idDst, input logic [dataWidth-1:0] immWord,
		input logic immSel);
		logic [dataWidth-1:0] left;
		logic [dataWidth-1:0] right;
		logic [dataWidth-1:0] value;
		@(posedge clk);
		#1;
		issue = 1'b1;
		op = opSel;
		srcA = idA;
		srcB = idB;
		dst = idDst;
		imm = immWord;
		useImm = immSel;
		left = modelRegs[idA];
		right = immSel ? immWord : modelRegs[idB];
		value = modelResult(opSel, left, right);
		expResult.push_back(value);
		expDst.push_back(idDst);
		expOverflow.push_back(modelOverflow(opSel, left, right));
		expCycle.push_back(cycleCount + 2);	// sampled next edge, valid one later.
		expName.push_back(name);
		modelRegs[idDst] = value;	// writes land in issue order.
	endtask

	task automatic idleCycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
			issue = 1'b0;
		end
	endtask

	always @(negedge clk) begin : watchOutputs
		logic [dataWidth-1:0] resultExp;
		logic [idWidth-1:0] dstExp;
		logic overflowExp;
		int cycleExp;
		string testName;
		if (!reset) begin
			if (resultValid) begin
				if (expResult.size() == 0) begin
					errors++;
					$display("Error: resultValid high with no instruction in flight");
				end else begin
					resultExp = expResult.pop_front();
					dstExp = expDst.pop_front();
					overflowExp = expOverflow.pop_front();
					cycleExp = expCycle.pop_front();
					testName = expName.pop_front();
					checkValue({testName, ".latency"}, cycleExp, cycleCount);
					checkValue({testName, ".result"}, 32'(resultExp), 32'(result));
					checkValue({testName, ".dst"}, 32'(dstExp), 32'(resultDst));
					checkValue({testName, ".zero"}, 32'(resultExp == '0), 32'(zero));
					checkValue({testName, ".negative"}, 32'(resultExp[dataWidth-1]),
						32'(negative));
					checkValue({testName, ".overflow"}, 32'(overflowExp), 32'(overflow));
				end
				haveResult = 1'b1;
				heldResult = result;
				heldDst = resultDst;
				heldOverflow = overflow;
			end else if (haveResult) begin	// outputs hold through a gap.
				checkValue("gapHold.result", 32'(heldResult), 32'(result));
				checkValue("gapHold.dst", 32'(heldDst), 32'(resultDst));
				checkValue("gapHold.overflow", 32'(heldOverflow), 32'(overflow));
			end
		end
	end

	initial begin : watchdog
		#(runLimit);
		$display("Timeout: the run did not finish within %0d time units", runLimit);
		$display("TEST FAIL");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] rnd;
		logic [idWidth-1:0] prevDst;
		logic [idWidth-1:0] nextDst;
		logic [idWidth-1:0] limitId;
		int pick;
		int assertFails;
		seed = 51;
		clk = 1'b0;
		reset = 1'b1;
		issue = 1'b0;
		op = opAdd;
		srcA = '0;
		srcB = '0;
		dst = '0;
		imm = '0;
		useImm = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			modelRegs[i] = '0;
		end
		edgeValues[0] = {1'b0, {(dataWidth - 1){1'b1}}};	// largest positive.
		edgeValues[1] = {1'b0, {(dataWidth - 2){1'b1}}, 1'b0};
		edgeValues[2] = {1'b1, {(dataWidth - 1){1'b0}}};	// most negative.
		edgeValues[3] = {1'b1, {(dataWidth - 2){1'b0}}, 1'b1};
		edgeValues[4] = '1;
		edgeValues[5] = dataWidth'(1);
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// a register or'd with itself reads back its reset value.
		for (int i = 0; i < regCount; i++) begin
			issueInstr("resetRead", opOr, idWidth'(i), idWidth'(i), idWidth'(i), '0, 1'b0);
		end

		for (int n = 0; n < randomCount; n++) begin
			issueInstr("random", randomOp(), randomId(), randomId(), randomId(),
				randomWord(), randomWord() > dataWidth'(maxSigned));
			rnd = $random(seed);
			if (rnd[1:0] == 2'b00) begin
				idleCycles(1 + int'(rnd[2]));
			end
		end

		prevDst = randomId();	// each srcA is the dst just before it.
		for (int n = 0; n < chainCount; n++) begin
			nextDst = randomId();
			rnd = $random(seed);
			issueInstr("forward", randomOp(), prevDst, randomId(), nextDst, randomWord(), rnd[0]);
			prevDst = nextDst;
		end

		for (int n = 0; n < gapCount; n++) begin
			issueInstr("gap", randomOp(), randomId(), randomId(), randomId(), randomWord(), 1'b1);
			rnd = $random(seed);
			idleCycles(2 + int'(rnd[0]));
		end

		for (int k = 0; k < limitRegs; k++) begin
			limitId = idWidth'(k + 1);
			issueInstr("overflowLoad", opAnd, limitId, limitId, limitId, '0, 1'b1);
			issueInstr("overflowLoad", opOr, limitId, limitId, limitId, edgeValues[k], 1'b1);
		end
		for (int n = 0; n < overflowCount; n++) begin
			rnd = $random(seed);
			pick = int'(rnd[15:8]) % 6;
			issueInstr("overflow", rnd[0] ? opSub : opAdd,
				idWidth'(1 + int'(rnd[3:1]) % limitRegs),
				idWidth'(1 + int'(rnd[6:4]) % limitRegs),
				idWidth'(limitRegs + 1 + int'(rnd[23:16]) % (regCount - limitRegs - 1)),
				edgeValues[pick], rnd[7]);
		end

		idleCycles(1);
		while (expResult.size() != 0) begin
			@(posedge clk);
		end
		idleCycles(2);
		assertFails = dut0.result0.checks0.resetFails + dut0.result0.checks0.overflowFails
			+ dut0.result0.checks0.flagFails;
		$display("Done: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/datapathAssertions.sv */
`default_nettype none

module datapathAssertions #(
	parameter int dataWidth = datapathPkg::defaultDataWidth
) (
	input logic clk,
	input logic reset,
	input logic issued,
	input datapathPkg::aluOp op,
	input logic resultValid,
	input logic [dataWidth-1:0] aluResult,
	input logic zero,
	input logic negative,
	input logic overflow
);

	import datapathPkg::*;

	int resetFails = 0;
	int overflowFails = 0;
	int flagFails = 0;
	logic arithOp;

	assign arithOp = (op == opAdd) || (op == opSub);

	// nothing can be in flight right after reset.
	resetQuiet: assert property (@(posedge clk) reset |=> !resultValid)
		else begin
			$error("resultValid high in the cycle after reset");
			resetFails++;
		end

	// logic and shift results never carry an overflow into the flag.
	logicNoOverflow: assert property (@(posedge clk) disable iff (reset)
		(issued && !arithOp) |=> !overflow)
		else begin
			$error("overflow flag set for a non-arithmetic operation");
			overflowFails++;
		end

	// flags follow the alu word that was loaded one cycle earlier.
	flagsMatch: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> ((zero == ($past(aluResult) == '0))
			&& (negative == $past(aluResult[dataWidth-1]))))
		else begin
			$error("zero or negative flag does not match the result");
			flagFails++;
		end

endmodule

bind resultStage datapathAssertions #(.dataWidth(dataWidth)) checks0 (
	.clk(clk), .reset(reset), .issued(issued), .op(op), .resultValid(resultValid),
	.aluResult(aluResult), .zero(zero), .negative(negative), .overflow(overflow)
);

`default_nettype wire

/* source/datapathTop.sv */
`default_nettype none

module datapathTop #(
	parameter int dataWidth = datapathPkg::defaultDataWidth,
	parameter int regCount = datapathPkg::defaultRegCount,
	localparam int idWidth = $clog2(regCount)
) (
	input logic clk,
	input logic reset,
	input logic issue,
	input datapathPkg::aluOp op,
	input logic [idWidth-1:0] srcA,
	input logic [idWidth-1:0] srcB,
	input logic [idWidth-1:0] dst,
	input logic [dataWidth-1:0] imm,
	input logic useImm,
	output logic resultValid,
	output logic [dataWidth-1:0] result,
	output logic [idWidth-1:0] resultDst,
	output logic zero,
	output logic negative,
	output logic overflow
);

	import datapathPkg::*;

	logic issued;
	aluOp issuedOp;
	logic [idWidth-1:0] readIdA;
	logic [idWidth-1:0] readIdB;
	logic [idWidth-1:0] issuedDst;
	logic [dataWidth-1:0] issuedImm;
	logic issuedUseImm;
	logic [dataWidth-1:0] readDataA;
	logic [dataWidth-1:0] readDataB;
	logic [dataWidth-1:0] aluResult;
	logic aluCarryOverflow;

	issueStage #(.dataWidth(dataWidth), .regCount(regCount)) issue0 (
		.clk(clk), .reset(reset), .issue(issue), .op(op),
		.srcA(srcA), .srcB(srcB), .dst(dst), .imm(imm), .useImm(useImm),
		.issued(issued), .issuedOp(issuedOp), .readIdA(readIdA), .readIdB(readIdB),
		.issuedDst(issuedDst), .issuedImm(issuedImm), .issuedUseImm(issuedUseImm)
	);

	// write-back comes straight from the result registers.
	registerFile #(.dataWidth(dataWidth), .regCount(regCount)) regFile0 (
		.clk(clk), .reset(reset),
		.writeEnable(resultValid), .writeId(resultDst), .writeData(result),
		.readIdA(readIdA), .readIdB(readIdB),
		.readDataA(readDataA), .readDataB(readDataB)
	);

	aluUnit #(.dataWidth(dataWidth)) alu0 (
		.op(issuedOp), .operandA(readDataA), .rightValue(readDataB),
		.immValue(issuedImm), .useImm(issuedUseImm),
		.aluResult(aluResult), .aluCarryOverflow(aluCarryOverflow)
	);

	resultStage #(.dataWidth(dataWidth), .regCount(regCount)) result0 (
		.clk(clk), .reset(reset), .issued(issued), .op(issuedOp),
		.aluResult(aluResult), .aluCarryOverflow(aluCarryOverflow), .dst(issuedDst),
		.resultValid(resultValid), .result(result), .resultDst(resultDst),
		.zero(zero), .negative(negative), .overflow(overflow)
	);

endmodule

`default_nettype wire

/* source/resultStage.sv */
`default_nettype none

module resultStage #(
	parameter int dataWidth = datapathPkg::defaultDataWidth,
	parameter int regCount = datapathPkg::defaultRegCount,
	localparam int idWidth = $clog2(regCount)
) (
	input logic clk,
	input logic reset,
	input logic issued,
	input datapathPkg::aluOp op,
	input logic [dataWidth-1:0] aluResult,
	input logic aluCarryOverflow,
	input logic [idWidth-1:0] dst,
	output logic resultValid,
	output logic [dataWidth-1:0] result,
	output logic [idWidth-1:0] resultDst,
	output logic zero,
	output logic negative,
	output logic overflow
);

	import datapathPkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= issued;
		end
	end

	// held until the next instruction lands.
	always_ff @(posedge clk) begin
		if (issued) begin
			result <= aluResult;
			resultDst <= dst;
			overflow <= aluCarryOverflow;
		end
	end

	assign zero = (result == '0);
	assign negative = result[dataWidth-1];	// sign bit of the held result.

endmodule

`default_nettype wire

/* source/aluUnit.sv */
`default_nettype none

module aluUnit #(
	parameter int dataWidth = datapathPkg::defaultDataWidth,
	localparam int shiftWidth = $clog2(dataWidth)
) (
	input datapathPkg::aluOp op,
	input logic [dataWidth-1:0] operandA,
	input logic [dataWidth-1:0] rightValue,
	input logic [dataWidth-1:0] immValue,
	input logic useImm,
	output logic [dataWidth-1:0] aluResult,
	output logic aluCarryOverflow
);

	import datapathPkg::*;

	localparam int msb = dataWidth - 1;

	logic [dataWidth-1:0] operandB;
	logic [shiftWidth-1:0] shiftAmount;
	logic [dataWidth-1:0] sumValue;
	logic [dataWidth-1:0] diffValue;
	logic addOverflow;
	logic subOverflow;

	// 2:1 select of operand b.
	always_comb begin
		case (useImm)
			1'b0: operandB = rightValue;
			1'b1: operandB = immValue;
			default: operandB = rightValue;
		endcase
	end

	assign shiftAmount = operandB[shiftWidth-1:0];	// low bits only.
	assign sumValue = operandA + operandB;
	assign diffValue = operandA - operandB;

	// same signs in, other sign out.
	assign addOverflow = (operandA[msb] == operandB[msb]) && (sumValue[msb] != operandA[msb]);
	// different signs in, sign of a lost.
	assign subOverflow = (operandA[msb] != operandB[msb]) && (diffValue[msb] != operandA[msb]);

	// 8:1 result select.
	always_comb begin
		case (op)
			opAdd: aluResult = sumValue;
			opSub: aluResult = diffValue;
			opAnd: aluResult = operandA & operandB;
			opOr: aluResult = operandA | operandB;
			opXor: aluResult = operandA ^ operandB;
			opShiftLeft: aluResult = operandA << shiftAmount;
			opShiftRightLogic: aluResult = operandA >> shiftAmount;
			opShiftRightArith: aluResult = $signed(operandA) >>> shiftAmount;
			default: aluResult = sumValue;
		endcase
	end

	always_comb begin
		case (op)
			opAdd: aluCarryOverflow = addOverflow;
			opSub: aluCarryOverflow = subOverflow;
			default: aluCarryOverflow = 1'b0;	// logic and shifts never overflow.
		endcase
	end

endmodule

`default_nettype wire

/* source/registerFile.sv */
`default_nettype none

module registerFile #(
	parameter int dataWidth = datapathPkg::defaultDataWidth,
	parameter int regCount = datapathPkg::defaultRegCount,
	localparam int idWidth = $clog2(regCount)
) (
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input logic [idWidth-1:0] writeId,
	input logic [dataWidth-1:0] writeData,
	input logic [idWidth-1:0] readIdA,
	input logic [idWidth-1:0] readIdB,
	output logic [dataWidth-1:0] readDataA,
	output logic [dataWidth-1:0] readDataB
);

	import datapathPkg::*;

	logic [dataWidth-1:0] regs [regCount];
	logic [regCount-1:0] wordline;
	logic [dataWidth-1:0] storedA;
	logic [dataWidth-1:0] storedB;

	// one-hot write decoder, all lines low without writeEnable.
	always_comb begin
		wordline = '0;
		for (int i = 0; i < regCount; i++) begin
			if (writeId == idWidth'(i)) begin
				wordline[i] = writeEnable;
			end
		end
	end

	// each register loads only on its own wordline.
	genvar g;
	generate
		for (g = 0; g < regCount; g++) begin : regSlot
			always_ff @(posedge clk) begin
				if (reset) begin
					regs[g] <= '0;
				end else if (wordline[g]) begin
					regs[g] <= writeData;
				end
			end
		end
	endgenerate

	// wide selection over every register.
	function automatic logic [dataWidth-1:0] selectReg(input logic [idWidth-1:0] id);
		logic [dataWidth-1:0] value;
		value = regs[0];
		for (int i = 0; i < regCount; i++) begin
			if (id == idWidth'(i)) begin
				value = regs[i];
			end
		end
		return value;
	endfunction

	// a pending write wins over the stored copy.
	function automatic logic [dataWidth-1:0] forwardReg(
		input logic [idWidth-1:0] id,
		input logic [dataWidth-1:0] stored
	);
		logic hit;
		hit = writeEnable && (writeId == id);
		return hit ? writeData : stored;
	endfunction

	always_comb begin
		storedA = selectReg(readIdA);
		storedB = selectReg(readIdB);
	end

	always_comb begin
		readDataA = forwardReg(readIdA, storedA);
		readDataB = forwardReg(readIdB, storedB);
	end

endmodule

`default_nettype wire

/* source/issueStage.sv */
`default_nettype none

module issueStage #(
	parameter int dataWidth = datapathPkg::defaultDataWidth,
	parameter int regCount = datapathPkg::defaultRegCount,
	localparam int idWidth = $clog2(regCount)
) (
	input logic clk,
	input logic reset,
	input logic issue,
	input datapathPkg::aluOp op,
	input logic [idWidth-1:0] srcA,
	input logic [idWidth-1:0] srcB,
	input logic [idWidth-1:0] dst,
	input logic [dataWidth-1:0] imm,
	input logic useImm,
	output logic issued,
	output datapathPkg::aluOp issuedOp,
	output logic [idWidth-1:0] readIdA,
	output logic [idWidth-1:0] readIdB,
	output logic [idWidth-1:0] issuedDst,
	output logic [dataWidth-1:0] issuedImm,
	output logic issuedUseImm
);

	import datapathPkg::*;

	// strobe follows issue by one cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			issued <= 1'b0;
		end else begin
			issued <= issue;
		end
	end

	// fields only move on a new instruction, so the read ports stay quiet in gaps.
	always_ff @(posedge clk) begin
		if (issue) begin
			issuedOp <= op;
			readIdA <= srcA;	// operand a register.
			readIdB <= srcB;	// operand b register, ignored with useImm.
			issuedDst <= dst;
			issuedImm <= imm;
			issuedUseImm <= useImm;
		end
	end

endmodule

`default_nettype wire

/* source/datapathPkg.sv */
`default_nettype none

package datapathPkg;

	localparam int defaultDataWidth = 16;	// word size of the slice.
	localparam int defaultRegCount = 16;	// every register has its own wordline.

	// operation select, one code per result of the eight-way mux.
	typedef enum logic [2:0] {
		opAdd             = 3'b000,
		opSub             = 3'b001,
		opAnd             = 3'b010,
		opOr              = 3'b011,
		opXor             = 3'b100,
		opShiftLeft       = 3'b101,
		opShiftRightLogic = 3'b110,	// zero fill.
		opShiftRightArith = 3'b111	// sign fill.
	} aluOp;

endpackage

`default_nettype wire
